/* cpu_isa_pkg.sv */
/*
 * 32-bit toy ISA with sixteen registers; r0 reads as zero and is never written.
 * Only register-form ALU ops, addi and halt exist; every other opcode is illegal.
 */
package cpu_isa_pkg;

    localparam int NUM_REGS = 16;

    typedef logic [31:0]                 data_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

    // major opcode, top 6 bits of every word
    typedef enum logic [5:0] {
        OP_ALU_R = 6'h01,
        OP_ADDI  = 6'h09,
        OP_HALT  = 6'h3f
    } opcode_t;

    // function select for register-form ops
    typedef enum logic [3:0] {
        FN_ADD = 4'h0,
        FN_SUB = 4'h1,
        FN_AND = 4'h2,
        FN_XOR = 4'h3
    } alu_funct_t;

    // register form: rd = rs1 op rs2
    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        alu_funct_t funct;
        logic [9:0] pad;
    } r_form_t;

    // immediate form: rd = rs1 + sext(imm)
    // opcode, rd and rs1 sit in the same bits as in the register form
    typedef struct packed {
        opcode_t     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        logic [1:0]  spare;
        logic [15:0] imm;
    } i_form_t;

    typedef union packed {
        r_form_t r;
        i_form_t i;
    } inst_t;

    // per-commit status
    typedef enum logic [1:0] {
        ST_OK      = 2'd0,
        ST_HALT    = 2'd1,
        ST_ILLEGAL = 2'd2
    } status_t;

endpackage

/* cpu_mem_pkg.sv */
/*
 * Word-addressed instruction memory, 16-bit addresses.
 * Queue depth must stay a power of two so the pointers wrap on their own.
 */
package cpu_mem_pkg;

    ////////////////////////////////
    // instruction memory
    ////////////////////////////////

    localparam int ADDR_W = 16;

    // one address per 32-bit word
    typedef logic [ADDR_W-1:0] addr_t;

    ////////////////////////////////
    // instruction queue
    ////////////////////////////////

    localparam int QUEUE_DEPTH = 4;

    // head and tail pointer width
    localparam int QPTR_W = 2;

    // occupancy counter, needs to hold 0 .. QUEUE_DEPTH
    localparam int QCNT_W = QPTR_W + 1;

endpackage

/* cpu_props.sv */
/*
 * Protocol checks bound into cpu_top; failures go through $error only.
 * fail_count lets the testbench fold assertion failures into its verdict.
 */
`timescale 1ns/1ps

module cpu_props (
    input logic clock,
    input logic rst,
    input logic mem_req,
    input logic mem_valid,
    input logic push,
    input logic full,
    input logic commit_en
);

    // bumped by every failing assertion
    int unsigned fail_count = 0;

    // a read has been issued and not yet answered
    logic outstanding;

    always_ff @(posedge clock) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (mem_req) begin
            outstanding <= 1'b1;
        end else if (mem_valid) begin
            outstanding <= 1'b0;
        end
    end

    ////////////////////////////////
    // memory and queue protocol
    ////////////////////////////////

    // one read in flight at most
    single_read: assert property (@(posedge clock) disable iff (rst)
        mem_req |-> !outstanding)
    else begin
        $error("mem_req while a read is still outstanding");
        fail_count++;
    end

    // full already counts the in-flight slot
    push_room: assert property (@(posedge clock) disable iff (rst)
        push |-> !full)
    else begin
        $error("push into a full instruction queue");
        fail_count++;
    end

    // commit register cleared by reset
    quiet_after_reset: assert property (@(posedge clock)
        rst |=> !commit_en)
    else begin
        $error("commit_en high in the cycle after reset");
        fail_count++;
    end

endmodule

bind cpu_top cpu_props u_props (
    .clock    (clock),
    .rst      (rst),
    .mem_req  (mem_req),
    .mem_valid(mem_valid),
    .push     (push),
    .full     (full),
    .commit_en(commit_en)
);

/* cpu_top.sv */
/*
 * Fetch, instruction queue and execution core behind a single-read memory port.
 * Memory must answer every mem_req with exactly one mem_valid, one cycle later or more.
 */
`timescale 1ns/1ps

module cpu_top (
    input  logic                  clock,
    input  logic                  rst,
    // instruction memory
    input  cpu_isa_pkg::data_t    mem_data,
    input  logic                  mem_valid,
    output logic                  mem_req,
    output cpu_mem_pkg::addr_t    mem_addr,
    // commit report
    output logic                  commit_en,
    output logic                  commit_wr_en,
    output cpu_isa_pkg::reg_idx_t commit_idx,
    output cpu_isa_pkg::data_t    commit_data,
    output cpu_mem_pkg::addr_t    commit_pc,
    output cpu_isa_pkg::status_t  commit_status,
    output logic                  halted
);
    import cpu_isa_pkg::*;
    import cpu_mem_pkg::*;

    // fetch to queue
    logic  push;
    inst_t push_inst;
    addr_t push_pc;
    logic  pending;
    logic  full;
    // core back to fetch and queue
    logic  halt_req;

    queue_if qbus ();

    fetch_unit u_fetch (
        .clock    (clock),
        .rst      (rst),
        .full     (full),
        .halt_req (halt_req),
        .mem_valid(mem_valid),
        .mem_data (mem_data),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .pending  (pending),
        .push     (push),
        .push_inst(push_inst),
        .push_pc  (push_pc)
    );

    inst_queue u_queue (
        .clock    (clock),
        .rst      (rst),
        .push     (push),
        .push_inst(push_inst),
        .push_pc  (push_pc),
        .pending  (pending),
        .halt_req (halt_req),
        .full     (full),
        .q        (qbus.queue)
    );

    exec_core u_core (
        .clock        (clock),
        .rst          (rst),
        .q            (qbus.core),
        .halt_req     (halt_req),
        .commit_en    (commit_en),
        .commit_wr_en (commit_wr_en),
        .commit_idx   (commit_idx),
        .commit_data  (commit_data),
        .commit_pc    (commit_pc),
        .commit_status(commit_status),
        .halted       (halted)
    );

endmodule

/* exec_core.sv */
/*
 * Single-cycle decode and execute; commit outputs are registered one cycle after take.
 * Halt or an illegal word commits with its status and stops the core for good.
 */
`timescale 1ns/1ps

module exec_core (
    input  logic                  clock,
    input  logic                  rst,
    // head of the instruction queue
    queue_if.core                 q,
    // stop fetch and queue
    output logic                  halt_req,
    // commit report
    output logic                  commit_en,
    output logic                  commit_wr_en,
    output cpu_isa_pkg::reg_idx_t commit_idx,
    output cpu_isa_pkg::data_t    commit_data,
    output cpu_mem_pkg::addr_t    commit_pc,
    output cpu_isa_pkg::status_t  commit_status,
    output logic                  halted
);
    import cpu_isa_pkg::*;

    // architectural registers, regs[0] is never written
    data_t   regs [NUM_REGS];

    inst_t   inst;
    data_t   src_a;
    data_t   src_b;
    data_t   imm_ext;
    data_t   result;
    status_t status;
    // instruction produces a register value
    logic    writes;
    // halt or illegal taken this cycle
    logic    stop;

    ////////////////////////////////
    // decode and operands
    ////////////////////////////////

    assign inst = q.inst;

    // rs1 and rd occupy the same bits in both forms, so the r view serves addi too
    assign src_a   = (inst.r.rs1 == '0) ? '0 : regs[inst.r.rs1];
    assign src_b   = (inst.r.rs2 == '0) ? '0 : regs[inst.r.rs2];
    // sign extended immediate
    assign imm_ext = {{16{inst.i.imm[15]}}, inst.i.imm};

    always_comb begin
        // anything not matched below is illegal
        result = '0;
        status = ST_ILLEGAL;
        writes = 1'b0;
        case (inst.r.opcode)
            OP_ALU_R: begin
                writes = 1'b1;
                status = ST_OK;
                case (inst.r.funct)
                    FN_ADD:  result = src_a + src_b;
                    FN_SUB:  result = src_a - src_b;
                    FN_AND:  result = src_a & src_b;
                    FN_XOR:  result = src_a ^ src_b;
                    // unknown function code counts as illegal
                    default: begin
                        writes = 1'b0;
                        status = ST_ILLEGAL;
                    end
                endcase
            end
            OP_ADDI: begin
                result = src_a + imm_ext;
                status = ST_OK;
                writes = 1'b1;
            end
            OP_HALT: status = ST_HALT;
            default: status = ST_ILLEGAL;
        endcase
    end

    ////////////////////////////////
    // take and stop
    ////////////////////////////////

    // consume the head as soon as it is there, never after stopping
    assign q.take = q.valid && !halted;

    assign stop = q.take && (status != ST_OK);
    // combinational so fetch is blocked in the very cycle of the halt
    assign halt_req = halted || stop;

    // register file write, same edge as the commit register
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (q.take && writes && inst.r.rd != '0) begin
            regs[inst.r.rd] <= result;
        end
    end

    ////////////////////////////////
    // commit report
    ////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            commit_en    <= 1'b0;
            commit_wr_en <= 1'b0;
            halted       <= 1'b0;
        end else begin
            commit_en    <= q.take;
            // writes to r0 are reported without a write
            commit_wr_en <= q.take && writes && inst.r.rd != '0;
            if (stop) halted <= 1'b1;
        end
    end

    // payload, only meaningful with commit_en
    always_ff @(posedge clock) begin
        if (q.take) begin
            commit_idx    <= inst.r.rd;
            commit_data   <= result;
            commit_pc     <= q.pc;
            commit_status <= status;
        end
    end

endmodule

/* fetch_unit.sv */
/*
 * Sequential word fetch starting at address 0, one memory read in flight at most.
 * Stops requesting once halt_req is seen; a read already in flight still returns.
 */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                 clock,
    input  logic                 rst,
    // queue has no room for another word
    input  logic                 full,
    // core stopped, no further fetching
    input  logic                 halt_req,
    // memory response strobe and word
    input  logic                 mem_valid,
    input  cpu_isa_pkg::data_t   mem_data,
    // memory request strobe and address
    output logic                 mem_req,
    output cpu_mem_pkg::addr_t   mem_addr,
    // a slot is reserved for a word still in flight
    output logic                 pending,
    // word forwarded to the queue
    output logic                 push,
    output cpu_isa_pkg::inst_t   push_inst,
    output cpu_mem_pkg::addr_t   push_pc
);
    import cpu_mem_pkg::*;

    // next address to fetch
    addr_t pc;
    // request issued, response not yet back
    logic  busy;
    // request decision this cycle
    logic  issue;

    ////////////////////////////////
    // request side
    ////////////////////////////////

    // only one read at a time, and only with room left in the queue
    assign issue = !busy && !full && !halt_req;

    always_ff @(posedge clock) begin
        if (rst) begin
            mem_req <= 1'b0;
            busy    <= 1'b0;
            pc      <= '0;
        end else begin
            // strobe lasts a single cycle
            mem_req <= issue;
            if (issue) begin
                busy <= 1'b1;
                pc   <= pc + 1'b1;
            end else if (mem_valid) begin
                busy <= 1'b0;
            end
        end
    end

    // address held until the response so it can tag the pushed word
    always_ff @(posedge clock) begin
        if (issue) begin
            mem_addr <= pc;
        end
    end

    ////////////////////////////////
    // response side
    ////////////////////////////////

    // response goes straight into the queue, same cycle
    assign push      = mem_valid && busy;
    assign push_inst = mem_data;
    assign push_pc   = mem_addr;

    // slot stays reserved until the word actually lands
    assign pending = busy && !mem_valid;

endmodule

/* inst_queue.sv */
/*
 * Circular FIFO of fetched words and their addresses, QUEUE_DEPTH entries.
 * full counts the in-flight read, so a push never finds the FIFO without room.
 */
`timescale 1ns/1ps

module inst_queue (
    input  logic               clock,
    input  logic               rst,
    // write side from fetch
    input  logic               push,
    input  cpu_isa_pkg::inst_t push_inst,
    input  cpu_mem_pkg::addr_t push_pc,
    // one word still on its way from memory
    input  logic               pending,
    // core stopped, late words are thrown away
    input  logic               halt_req,
    output logic               full,
    // head entry to the core
    queue_if.queue             q
);
    import cpu_isa_pkg::*;
    import cpu_mem_pkg::*;

    // storage, no reset needed
    inst_t inst_mem [QUEUE_DEPTH];
    addr_t pc_mem   [QUEUE_DEPTH];

    logic [QPTR_W-1:0] head;
    logic [QPTR_W-1:0] tail;
    logic [QCNT_W-1:0] count;

    logic wr;
    logic rd;

    // drop whatever arrives after the core has stopped
    assign wr = push && !halt_req;
    assign rd = q.take;

    // last free slot already promised to the outstanding read
    assign full = (count == QCNT_W'(QUEUE_DEPTH)) ||
                  (count == QCNT_W'(QUEUE_DEPTH - 1) && pending);

    always_ff @(posedge clock) begin
        if (wr) begin
            inst_mem[tail] <= push_inst;
            pc_mem[tail]   <= push_pc;
        end
    end

    ////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // pointers wrap at the power-of-two depth
            if (wr) tail <= tail + 1'b1;
            if (rd) head <= head + 1'b1;
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head shown from storage, visible the cycle after its push
    assign q.valid = (count != '0);
    assign q.inst  = inst_mem[head];
    assign q.pc    = pc_mem[head];

endmodule

/* queue_if.sv */
/*
 * Head of the instruction queue as seen by the execution core.
 * take pops the head at the clock edge and is legal only while valid is high.
 */
`timescale 1ns/1ps

interface queue_if;
    import cpu_isa_pkg::*;
    import cpu_mem_pkg::*;

    // head entry present
    logic  valid;
    // head instruction word and its address
    inst_t inst;
    addr_t pc;
    // pop strobe from the core
    logic  take;

    modport queue (
        output valid, inst, pc,
        input  take
    );

    modport core (
        input  valid, inst, pc,
        output take
    );

endinterface

/* run.sh */
#!/bin/sh
# Compile and run the cpu testbench with Verilator.
# Exits 0 only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cpu -f tb.f -o sim_tb_cpu
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_tb_cpu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* tb.f */
cpu_isa_pkg.sv
cpu_mem_pkg.sv
queue_if.sv
fetch_unit.sv
inst_queue.sv
exec_core.sv
cpu_top.sv
cpu_props.sv
tb_cpu.sv

/* tb_cpu.sv */
/*
 * Random programs of ALU ops and addi checked against an ISA model, run twice.
 * Memory answers each read after 1 to 4 cycles; second run stops on an illegal word.
 */
`timescale 1ns/1ps

module tb_cpu;
    import cpu_isa_pkg::*;
    import cpu_mem_pkg::*;

    localparam int          PROG_LEN     = 48;
    localparam int          MEM_WORDS    = 64;
    localparam int          ILLEGAL_AT   = 20;
    localparam int          WAIT_LIMIT   = 2000;
    localparam int          QUIET_CYCLES = 50;
    localparam logic [31:0] SEED         = 32'ha09f5138;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] TAPS         = 32'h80200003;
    localparam logic [5:0]  BAD_OPCODE   = 6'h2a;

    logic     clock;
    logic     rst;
    data_t    mem_data;
    logic     mem_valid;
    logic     mem_req;
    addr_t    mem_addr;
    logic     commit_en;
    logic     commit_wr_en;
    reg_idx_t commit_idx;
    data_t    commit_data;
    addr_t    commit_pc;
    status_t  commit_status;
    logic     halted;

    // random source and memory model state
    logic [31:0] lfsr;
    logic [31:0] lat_draw;
    data_t       prog_mem [MEM_WORDS];
    logic        mem_busy;
    int          mem_wait;
    addr_t       mem_addr_q;

    // expected commit sequence from the ISA model
    addr_t    exp_pc     [MEM_WORDS];
    reg_idx_t exp_idx    [MEM_WORDS];
    data_t    exp_data   [MEM_WORDS];
    logic     exp_wr     [MEM_WORDS];
    status_t  exp_status [MEM_WORDS];
    int       exp_count;

    int seen;
    int late_reqs;
    int errors;
    int timeouts;
    int total;
    bit ok;

    cpu_top UUT (
        .clock        (clock),
        .rst          (rst),
        .mem_data     (mem_data),
        .mem_valid    (mem_valid),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .commit_en    (commit_en),
        .commit_wr_en (commit_wr_en),
        .commit_idx   (commit_idx),
        .commit_data  (commit_data),
        .commit_pc    (commit_pc),
        .commit_status(commit_status),
        .halted       (halted)
    );

    always #2 clock = ~clock;

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = next_lfsr(lfsr);
        end
    endtask

    // unprogrammed words, unique per address
    function automatic data_t fill_word(input addr_t a);
        return {~a, a};
    endfunction

    function automatic data_t fetch_word(input addr_t a);
        if (int'(a) < MEM_WORDS) return prog_mem[a[5:0]];
        else return fill_word(a);
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    //////////////////////////////
    // program and ISA model
    //////////////////////////////

    task automatic build_program(input bit with_illegal);
        logic [31:0] kind;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] fn;
        logic [31:0] imm;
        for (int a = 0; a < MEM_WORDS; a++) begin
            prog_mem[a] = fill_word(addr_t'(a));
        end
        for (int w = 0; w < PROG_LEN; w++) begin
            draw_bits(1, kind);
            draw_bits(4, rd);
            draw_bits(4, rs1);
            if (kind[0]) begin
                draw_bits(16, imm);
                prog_mem[w] = {OP_ADDI, rd[3:0], rs1[3:0], 2'b00, imm[15:0]};
            end else begin
                draw_bits(4, rs2);
                draw_bits(2, fn);
                prog_mem[w] = {OP_ALU_R, rd[3:0], rs1[3:0], rs2[3:0], 2'b00, fn[1:0], 10'h0};
            end
        end
        // addi into r0, then r0 used as a source
        prog_mem[2] = {OP_ADDI, 4'd0, 4'd5, 2'b00, 16'h8001};
        prog_mem[3] = {OP_ALU_R, 4'd7, 4'd0, 4'd9, 2'b00, 2'd0, 10'h0};
        prog_mem[PROG_LEN] = {OP_HALT, 26'h0};
        if (with_illegal) begin
            draw_bits(26, imm);
            prog_mem[ILLEGAL_AT] = {BAD_OPCODE, imm[25:0]};
        end
    endtask

    // runs from word 0 until halt or an illegal word
    task automatic run_model();
        data_t      regs [NUM_REGS];
        data_t      word;
        data_t      a;
        data_t      b;
        data_t      res;
        logic [5:0] op;
        reg_idx_t   rd;
        status_t    st;
        int         pc;
        for (int r = 0; r < NUM_REGS; r++) begin
            regs[r] = '0;
        end
        exp_count = 0;
        pc        = 0;
        st        = ST_OK;
        while (st == ST_OK && pc < MEM_WORDS) begin
            word = prog_mem[pc];
            op   = word[31:26];
            rd   = word[25:22];
            a    = regs[word[21:18]];
            b    = regs[word[17:14]];
            res  = '0;
            st   = ST_OK;
            if (op == OP_ALU_R) begin
                case (word[13:10])
                    4'h0:    res = a + b;
                    4'h1:    res = a - b;
                    4'h2:    res = a & b;
                    4'h3:    res = a ^ b;
                    default: st = ST_ILLEGAL;
                endcase
            end else if (op == OP_ADDI) begin
                res = a + {{16{word[15]}}, word[15:0]};
            end else if (op == OP_HALT) begin
                st = ST_HALT;
            end else begin
                st = ST_ILLEGAL;
            end
            exp_pc[exp_count]     = addr_t'(pc);
            exp_idx[exp_count]    = rd;
            exp_data[exp_count]   = res;
            exp_status[exp_count] = st;
            exp_wr[exp_count]     = (st == ST_OK) && (rd != '0);
            // r0 stays zero
            if (exp_wr[exp_count]) regs[rd] = res;
            exp_count++;
            pc++;
        end
    endtask

    //////////////////////////////
    // memory model and monitor
    //////////////////////////////

    always @(negedge clock) begin
        mem_valid = 1'b0;
        if (mem_busy) begin
            if (mem_wait == 0) begin
                mem_valid = 1'b1;
                mem_data  = fetch_word(mem_addr_q);
                mem_busy  = 1'b0;
            end else begin
                mem_wait--;
            end
        end
        if (mem_req === 1'b1) begin
            if (mem_busy) begin
                errors++;
                $display("memory got a second read while one was still in flight");
            end
            mem_busy   = 1'b1;
            mem_addr_q = mem_addr;
            // answer 1 to 4 cycles later
            draw_bits(2, lat_draw);
            mem_wait = int'(lat_draw);
        end
    end

    always @(negedge clock) begin
        if (commit_en === 1'b1) begin
            if (seen < exp_count) begin
                compare_value("commit_pc", 32'(commit_pc), 32'(exp_pc[seen]));
                compare_value("commit_status", 32'(commit_status), 32'(exp_status[seen]));
                compare_value("commit_wr_en", 32'(commit_wr_en), 32'(exp_wr[seen]));
                compare_value("halted", 32'(halted), 32'(exp_status[seen] != ST_OK));
                if (exp_status[seen] == ST_OK) begin
                    compare_value("commit_idx", 32'(commit_idx), 32'(exp_idx[seen]));
                    compare_value("commit_data", commit_data, exp_data[seen]);
                end
            end else begin
                errors++;
                $display("[ERROR] %0t: commit at pc %0d after the last expected one",
                         $time, commit_pc);
            end
            seen++;
        end
        if (halted === 1'b1 && mem_req === 1'b1) late_reqs++;
    end

    //////////////////////////////
    // runs
    //////////////////////////////

    task automatic run_test(input bit with_illegal, output bit done_ok);
        int cycles;
        done_ok = 1'b1;
        rst     = 1'b1;
        build_program(with_illegal);
        run_model();
        seen      = 0;
        late_reqs = 0;
        repeat (2) @(negedge clock);
        rst    = 1'b0;
        cycles = 0;
        while (halted !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("timeout: halted did not rise within %0d cycles", WAIT_LIMIT);
            timeouts++;
            done_ok = 1'b0;
        end else begin
            // no commit and no fetch after the stop
            repeat (QUIET_CYCLES) @(negedge clock);
            compare_value("commit count", 32'(seen), 32'(exp_count));
            if (late_reqs != 0) begin
                errors++;
                $display("mem_req was issued %0d times after halted rose", late_reqs);
            end
        end
    endtask

    initial begin
        clock      = 1'b0;
        rst        = 1'b1;
        mem_valid  = 1'b0;
        mem_data   = '0;
        lfsr       = SEED;
        mem_busy   = 1'b0;
        mem_wait   = 0;
        mem_addr_q = '0;
        errors     = 0;
        timeouts   = 0;
        seen       = 0;
        late_reqs  = 0;
        exp_count  = 0;
        run_test(1'b0, ok);
        if (ok) run_test(1'b1, ok);
        total = errors + timeouts + int'(UUT.u_props.fail_count);
        $display("errors: %0d checks, %0d timeouts, %0d assertions", errors, timeouts,
                 UUT.u_props.fail_count);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
